// ==== src/state_lsu_pkg.sv ====
package state_lsu_pkg;

    // Channel geometry of the memory port
    localparam int ADDR_W = 32;
    localparam int ID_W   = 4;
    localparam int DATA_W = 64;
    localparam int STRB_W = 8;
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } a_item_t;

    typedef struct packed {
        logic              last;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] data;
    } w_item_t;

    // Stream words needed per queue item, rounded up
    localparam int A_ITEM_WORDS = ($bits(a_item_t) + WORD_W - 1) / WORD_W;
    localparam int W_ITEM_WORDS = ($bits(w_item_t) + WORD_W - 1) / WORD_W;

    typedef enum logic [3:0] {
        OP_FINISH = 4'b0000,
        OP_MUL    = 4'b0010,
        OP_ROUTE  = 4'b0100,
        OP_LOAD   = 4'b0101,
        OP_BURST  = 4'b1101
    } op_t;

    typedef enum logic [3:0] {
        ROUTE_A   = 4'b0000,
        ROUTE_W   = 4'b0001,
        ROUTE_CNT = 4'b1000
    } route_t;

    typedef enum logic [3:0] {
        SIZE_1   = 4'b0000,
        SIZE_CNT = 4'b0001
    } size_t;

    // Operand field, meaning depends on the opcode
    typedef union packed {
        route_t     route;
        size_t      size;
        logic [3:0] factor;
    } arg_u;

    typedef struct packed {
        op_t  op;
        arg_u arg;
    } instr_t;

    typedef logic [4:0] pc_t;

    typedef struct packed {
        route_t route;
        word_t  len;
    } burst_cmd_t;

endpackage

// ==== src/lsu_microcode_rom.sv ====
`timescale 1ns/1ns

module lsu_microcode_rom import state_lsu_pkg::*; (
    input  pc_t    pc,
    output instr_t instr
);

    function automatic instr_t mk(op_t op, logic [3:0] arg);
        instr_t i;
        i.op         = op;
        i.arg.factor = arg;
        return i;
    endfunction

    always_comb begin
        case (pc)
            // A channel
            5'h00: instr = mk(OP_LOAD,  ROUTE_A);
            5'h01: instr = mk(OP_ROUTE, ROUTE_CNT);
            5'h02: instr = mk(OP_BURST, SIZE_1);
            5'h03: instr = mk(OP_MUL,   4'(A_ITEM_WORDS));
            5'h04: instr = mk(OP_ROUTE, ROUTE_A);
            5'h05: instr = mk(OP_BURST, SIZE_CNT);

            // W channel
            5'h06: instr = mk(OP_LOAD,  ROUTE_W);
            5'h07: instr = mk(OP_ROUTE, ROUTE_CNT);
            5'h08: instr = mk(OP_BURST, SIZE_1);
            5'h09: instr = mk(OP_MUL,   4'(W_ITEM_WORDS));
            5'h0a: instr = mk(OP_ROUTE, ROUTE_W);
            5'h0b: instr = mk(OP_BURST, SIZE_CNT);

            5'h0c: instr = mk(OP_FINISH, 4'b0000);

            // Unused space ends the procedure
            default: instr = mk(OP_FINISH, 4'b0000);
        endcase
    end

endmodule

// ==== src/lsu_sequencer.sv ====
`timescale 1ns/1ns

module lsu_sequencer import state_lsu_pkg::*; #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   save,
    input  logic [COUNT_WIDTH-1:0] a_cnt,
    input  logic [COUNT_WIDTH-1:0] w_cnt,
    input  instr_t                 instr,
    input  logic                   burst_done,
    output pc_t                    pc,
    output logic                   burst_start,
    output burst_cmd_t             burst_cmd,
    output word_t                  cnt_word,
    output logic                   complete,
    output logic                   busy
);

    // Headroom for the largest 4-bit MUL factor
    localparam int CNT_W = COUNT_WIDTH + 4;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        DECODE,
        BURST_CMD,
        BURST_WAIT
    } state_t;

    state_t           state;
    state_t           state_next;
    instr_t           ins;
    logic [CNT_W-1:0] cnt;
    route_t           route;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (save) begin
                    state_next = FETCH;
                end
            end
            FETCH: begin
                state_next = DECODE;
            end
            DECODE: begin
                case (ins.op)
                    OP_MUL, OP_ROUTE, OP_LOAD: state_next = FETCH;
                    OP_BURST:                  state_next = BURST_CMD;
                    default:                   state_next = IDLE;
                endcase
            end
            BURST_CMD: begin
                state_next = BURST_WAIT;
            end
            BURST_WAIT: begin
                if (burst_done) begin
                    state_next = FETCH;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            pc    <= '0;
            ins   <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE) begin
                pc <= '0;
            end else if (state == FETCH) begin
                ins <= instr;
                pc  <= pc + pc_t'(1);
            end
        end
    end

    // Count and route registers, updated while decoding
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            route <= ROUTE_CNT;
        end else if (state == DECODE) begin
            case (ins.op)
                OP_LOAD: begin
                    if (ins.arg.route == ROUTE_W) begin
                        cnt <= {4'd0, w_cnt};
                    end else begin
                        cnt <= {4'd0, a_cnt};
                    end
                end
                OP_MUL:   cnt   <= cnt * CNT_W'(ins.arg.factor);
                OP_ROUTE: route <= ins.arg.route;
                default:  ;
            endcase
        end
    end

    assign cnt_word = word_t'(cnt);

    always_comb begin
        burst_cmd.route = route;
        burst_cmd.len   = (ins.arg.size == SIZE_CNT) ? cnt_word : word_t'(1);
    end

    assign burst_start = state == BURST_CMD;
    assign complete    = state == DECODE && ins.op == OP_FINISH;
    assign busy        = state != IDLE;

endmodule

// ==== src/channel_encoder.sv ====
`timescale 1ns/1ns

module channel_encoder import state_lsu_pkg::*; #(
    parameter int ITEM_WORDS = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sel,
    input  logic                         item_valid,
    input  logic [ITEM_WORDS*WORD_W-1:0] item,
    output logic                         item_ready,
    output logic                         word_valid,
    output word_t                        word,
    input  logic                         word_ready
);

    localparam int IDX_W = $clog2(ITEM_WORDS + 1);

    logic                         full;
    logic [IDX_W-1:0]             left;
    logic [ITEM_WORDS*WORD_W-1:0] shift;

    // Queue only moves while routed, empty and not stalled downstream
    assign item_ready = sel && !full && word_ready;

    assign word_valid = full;
    assign word       = shift[WORD_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
            left <= '0;
        end else if (item_valid && item_ready) begin
            full <= 1'b1;
            left <= IDX_W'(ITEM_WORDS - 1);
        end else if (word_valid && word_ready) begin
            if (left == '0) begin
                full <= 1'b0;
            end else begin
                left <= left - IDX_W'(1);
            end
        end
    end

    // Lowest word goes out first
    always_ff @(posedge clk) begin
        if (item_valid && item_ready) begin
            shift <= item;
        end else if (word_valid && word_ready) begin
            shift <= shift >> WORD_W;
        end
    end

endmodule

// ==== src/save_burst_mux.sv ====
`timescale 1ns/1ns

module save_burst_mux import state_lsu_pkg::*; #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       burst_start,
    input  burst_cmd_t burst_cmd,
    input  word_t      cnt_word,
    output logic       a_sel,
    input  logic       a_valid,
    output logic       a_ready,
    input  word_t      a_word,
    output logic       w_sel,
    input  logic       w_valid,
    output logic       w_ready,
    input  word_t      w_word,
    output logic       out_valid,
    input  logic       out_ready,
    output word_t      out_data,
    output logic       burst_done
);

    // Wide enough for a count times the largest item factor
    localparam int LEN_W = COUNT_WIDTH + 4;

    logic             active;
    route_t           route;
    logic [LEN_W-1:0] remaining;
    logic             pending;

    assign pending    = active && remaining != '0;
    assign burst_done = active && remaining == '0;

    assign a_sel   = pending && route == ROUTE_A;
    assign w_sel   = pending && route == ROUTE_W;
    assign a_ready = a_sel && out_ready;
    assign w_ready = w_sel && out_ready;

    always_comb begin
        case (route)
            ROUTE_A:   {out_valid, out_data} = {a_sel && a_valid, a_word};
            ROUTE_W:   {out_valid, out_data} = {w_sel && w_valid, w_word};
            ROUTE_CNT: {out_valid, out_data} = {pending, cnt_word};
            default:   {out_valid, out_data} = {1'b0, word_t'(0)};
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            route     <= ROUTE_CNT;
            remaining <= '0;
        end else if (burst_start) begin
            active    <= 1'b1;
            route     <= burst_cmd.route;
            remaining <= burst_cmd.len[LEN_W-1:0];
        end else if (burst_done) begin
            active <= 1'b0;
        end else if (out_valid && out_ready) begin
            remaining <= remaining - LEN_W'(1);
        end
    end

endmodule

// ==== src/state_lsu_top.sv ====
`timescale 1ns/1ns

module state_lsu_top import state_lsu_pkg::*; #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   save,
    input  logic                   fifo_a_valid,
    output logic                   fifo_a_ready,
    input  a_item_t                fifo_a_item,
    input  logic                   fifo_w_valid,
    output logic                   fifo_w_ready,
    input  w_item_t                fifo_w_item,
    input  logic [COUNT_WIDTH-1:0] a_cnt,
    input  logic [COUNT_WIDTH-1:0] w_cnt,
    output logic                   out_valid,
    input  logic                   out_ready,
    output word_t                  out_data,
    output logic                   complete,
    output logic                   busy
);

    pc_t        pc;
    instr_t     instr;
    logic       burst_start;
    logic       burst_done;
    burst_cmd_t burst_cmd;
    word_t      cnt_word;
    logic       a_sel;
    logic       a_valid;
    logic       a_ready;
    word_t      a_word;
    logic       w_sel;
    logic       w_valid;
    logic       w_ready;
    word_t      w_word;

    lsu_microcode_rom rom_i (
        .pc    (pc),
        .instr (instr)
    );

    lsu_sequencer #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) seq_i (
        .clk         (clk),
        .rst         (rst),
        .save        (save),
        .a_cnt       (a_cnt),
        .w_cnt       (w_cnt),
        .instr       (instr),
        .burst_done  (burst_done),
        .pc          (pc),
        .burst_start (burst_start),
        .burst_cmd   (burst_cmd),
        .cnt_word    (cnt_word),
        .complete    (complete),
        .busy        (busy)
    );

    save_burst_mux #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) mux_i (
        .clk         (clk),
        .rst         (rst),
        .burst_start (burst_start),
        .burst_cmd   (burst_cmd),
        .cnt_word    (cnt_word),
        .a_sel       (a_sel),
        .a_valid     (a_valid),
        .a_ready     (a_ready),
        .a_word      (a_word),
        .w_sel       (w_sel),
        .w_valid     (w_valid),
        .w_ready     (w_ready),
        .w_word      (w_word),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .burst_done  (burst_done)
    );

    // Items are zero-extended to a whole number of words
    channel_encoder #(
        .ITEM_WORDS (A_ITEM_WORDS)
    ) enc_a (
        .clk        (clk),
        .rst        (rst),
        .sel        (a_sel),
        .item_valid (fifo_a_valid),
        .item       ((A_ITEM_WORDS*WORD_W)'(fifo_a_item)),
        .item_ready (fifo_a_ready),
        .word_valid (a_valid),
        .word       (a_word),
        .word_ready (a_ready)
    );

    channel_encoder #(
        .ITEM_WORDS (W_ITEM_WORDS)
    ) enc_w (
        .clk        (clk),
        .rst        (rst),
        .sel        (w_sel),
        .item_valid (fifo_w_valid),
        .item       ((W_ITEM_WORDS*WORD_W)'(fifo_w_item)),
        .item_ready (fifo_w_ready),
        .word_valid (w_valid),
        .word       (w_word),
        .word_ready (w_ready)
    );

endmodule

// ==== sim/state_lsu_assert.sv ====
`timescale 1ns/1ns

module state_lsu_assert import state_lsu_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  burst_start,
    input logic  burst_done,
    input logic  a_sel,
    input logic  w_sel,
    input logic  out_valid,
    input logic  out_ready,
    input word_t out_data
);

    // Burst window seen from the command side
    logic in_burst;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_burst <= 1'b0;
        end else if (burst_start) begin
            in_burst <= 1'b1;
        end else if (burst_done) begin
            in_burst <= 1'b0;
        end
    end

    out_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("output word dropped or changed before it was accepted");

    one_sel: assert property (@(posedge clk) disable iff (rst) $onehot0({a_sel, w_sel}))
        else $error("both channel encoders selected at once");

    done_in_burst: assert property (@(posedge clk) disable iff (rst) burst_done |-> in_burst)
        else $error("burst_done raised with no burst active");

endmodule

bind save_burst_mux state_lsu_assert assert_i (
    .clk         (clk),
    .rst         (rst),
    .burst_start (burst_start),
    .burst_done  (burst_done),
    .a_sel       (a_sel),
    .w_sel       (w_sel),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_data    (out_data)
);

// ==== sim/state_lsu_tb.sv ====
`timescale 1ns/1ns

module state_lsu_tb import state_lsu_pkg::*; ();

    localparam int COUNT_WIDTH  = 16;
    localparam int RESET_CYCLES = 16;
    localparam int SEED         = 60817;

    // Stream words per queue item
    localparam int A_WORDS = 2;
    localparam int W_WORDS = 3;

    function automatic int words_in(int na, int nw);
        return 2 + na * A_WORDS + nw * W_WORDS;
    endfunction

    localparam int TOTAL_WORDS = 2 * words_in(3, 2) + words_in(0, 0) + words_in(4, 3)
                               + 2 * words_in(1, 2);
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * TOTAL_WORDS + 100 * 6;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   save;
    logic                   fifo_a_valid;
    logic                   fifo_a_ready;
    a_item_t                fifo_a_item;
    logic                   fifo_w_valid;
    logic                   fifo_w_ready;
    w_item_t                fifo_w_item;
    logic [COUNT_WIDTH-1:0] a_cnt;
    logic [COUNT_WIDTH-1:0] w_cnt;
    logic                   out_valid;
    logic                   out_ready;
    word_t                  out_data;
    logic                   complete;
    logic                   busy;

    // Queue contents, appended test after test
    a_item_t a_items [0:31];
    w_item_t w_items [0:31];
    int      a_end = 0;
    int      w_end = 0;
    word_t   exp_q [$];
    string   test_name = "reset";
    logic    bp_on = 1'b0;
    logic    gaps_on = 1'b0;

    // Running totals kept by the comparator
    int   cycles = 0;
    int   a_idx = 0;
    int   w_idx = 0;
    int   got_idx = 0;
    int   complete_cnt = 0;
    logic busy_ref = 1'b0;

    int a_shown = 0;
    int w_shown = 0;

    always #10 clk = ~clk;

    state_lsu_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .save         (save),
        .fifo_a_valid (fifo_a_valid),
        .fifo_a_ready (fifo_a_ready),
        .fifo_a_item  (fifo_a_item),
        .fifo_w_valid (fifo_w_valid),
        .fifo_w_ready (fifo_w_ready),
        .fifo_w_item  (fifo_w_item),
        .a_cnt        (a_cnt),
        .w_cnt        (w_cnt),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .complete     (complete),
        .busy         (busy)
    );

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (exp !== act) begin
            stop_on_error($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            stop_on_error($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_level(string name, logic exp, logic act);
        if (exp !== act) begin
            stop_on_error($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Count word, then every item split into words lowest first, per channel
    function automatic void build_expected(int na, int nw, int a_first, int w_first);
        logic [A_WORDS*32-1:0] a_bits;
        logic [W_WORDS*32-1:0] w_bits;
        exp_q.push_back(word_t'(na));
        for (int i = 0; i < na; i++) begin
            a_bits = (A_WORDS*32)'(a_items[a_first + i]);
            for (int k = 0; k < A_WORDS; k++) begin
                exp_q.push_back(a_bits[k*32 +: 32]);
            end
        end
        exp_q.push_back(word_t'(nw));
        for (int i = 0; i < nw; i++) begin
            w_bits = (W_WORDS*32)'(w_items[w_first + i]);
            for (int k = 0; k < W_WORDS; k++) begin
                exp_q.push_back(w_bits[k*32 +: 32]);
            end
        end
    endfunction

    // Queue models and output back-pressure
    initial begin
        fifo_a_valid = 1'b0;
        fifo_a_item  = '0;
        fifo_w_valid = 1'b0;
        fifo_w_item  = '0;
        out_ready    = 1'b0;
        forever begin
            @(negedge clk);
            // Hold an offered item until it is taken
            if (!(fifo_a_valid && a_shown == a_idx)) begin
                a_shown      = a_idx;
                fifo_a_valid = (a_idx < a_end) && (!gaps_on || $urandom_range(0, 2) != 0);
                if (fifo_a_valid) begin
                    fifo_a_item = a_items[a_idx];
                end
            end
            if (!(fifo_w_valid && w_shown == w_idx)) begin
                w_shown      = w_idx;
                fifo_w_valid = (w_idx < w_end) && (!gaps_on || $urandom_range(0, 2) != 0);
                if (fifo_w_valid) begin
                    fifo_w_item = w_items[w_idx];
                end
            end
            out_ready = !bp_on || ($urandom_range(0, 3) != 0);
        end
    end

    // Comparator
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout after %0d cycles in test %s", cycles, test_name));
        end
        if (rst) begin
            busy_ref = 1'b0;
        end else begin
            check_level({test_name, " busy"}, busy_ref, busy);
            // A stalled stream takes nothing from the queues
            if (!out_ready) begin
                check_level({test_name, " A item taken while stalled"}, 1'b0,
                            fifo_a_valid && fifo_a_ready);
                check_level({test_name, " W item taken while stalled"}, 1'b0,
                            fifo_w_valid && fifo_w_ready);
            end
            if (fifo_a_valid && fifo_a_ready) begin
                a_idx++;
            end
            if (fifo_w_valid && fifo_w_ready) begin
                w_idx++;
            end
            if (out_valid && out_ready) begin
                if (got_idx >= exp_q.size()) begin
                    stop_on_error($sformatf("unexpected extra word %h in test %s",
                                            out_data, test_name));
                end else begin
                    check_word(test_name, exp_q[got_idx], out_data);
                    got_idx++;
                end
            end
            if (complete) begin
                check_count({test_name, " words before complete"}, exp_q.size(), got_idx);
                complete_cnt++;
            end
            busy_ref = busy_ref ? !complete : save;
        end
    end

    task automatic run_save(string name, int na, int nw, logic bp, logic gaps, logic hold);
        int runs_before;
        test_name = name;
        bp_on     = bp;
        gaps_on   = gaps;
        for (int i = 0; i < na; i++) begin
            a_items[a_end + i].id   = ID_W'($urandom);
            a_items[a_end + i].addr = $urandom;
        end
        for (int i = 0; i < nw; i++) begin
            w_items[w_end + i].data = {$urandom, $urandom};
            w_items[w_end + i].strb = STRB_W'($urandom);
            w_items[w_end + i].last = (i == nw - 1);
        end
        build_expected(na, nw, a_end, w_end);
        a_end       = a_end + na;
        w_end       = w_end + nw;
        a_cnt       = COUNT_WIDTH'(na);
        w_cnt       = COUNT_WIDTH'(nw);
        runs_before = complete_cnt;
        save = 1'b1;
        if (hold) begin
            repeat (20) @(negedge clk);
            check_count({name, " complete while save held"}, runs_before, complete_cnt);
        end else begin
            @(negedge clk);
        end
        save = 1'b0;
        wait (complete_cnt == runs_before + 1);
        repeat (4) @(negedge clk);
        check_count({name, " words"}, exp_q.size(), got_idx);
        check_count({name, " complete pulses"}, runs_before + 1, complete_cnt);
        check_count({name, " A items taken"}, a_end, a_idx);
        check_count({name, " W items taken"}, w_end, w_idx);
    endtask

    initial begin
        rst   = 1'b1;
        save  = 1'b0;
        a_cnt = '0;
        w_cnt = '0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(negedge clk);
        check_level("reset out_valid", 1'b0, out_valid);
        check_level("reset complete", 1'b0, complete);
        check_level("reset busy", 1'b0, busy);
        check_level("reset fifo_a_ready", 1'b0, fifo_a_ready);
        check_level("reset fifo_w_ready", 1'b0, fifo_w_ready);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        run_save("basic", 3, 2, 1'b0, 1'b0, 1'b0);
        run_save("back-pressure", 3, 2, 1'b1, 1'b0, 1'b0);
        run_save("empty queues", 0, 0, 1'b0, 1'b0, 1'b0);
        run_save("queue gaps", 4, 3, 1'b0, 1'b1, 1'b0);
        run_save("save held", 1, 2, 1'b0, 1'b0, 1'b1);
        run_save("second save", 1, 2, 1'b0, 1'b0, 1'b0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== all.f ====
src/state_lsu_pkg.sv
src/lsu_microcode_rom.sv
src/lsu_sequencer.sv
src/channel_encoder.sv
src/save_burst_mux.sv
src/state_lsu_top.sv
sim/state_lsu_assert.sv
sim/state_lsu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := state_lsu_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard src/*.sv sim/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || { echo "Simulation ended without passing"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
